// ==== all.f ====
design/ser_tx_pkg.sv
design/ser_tx_regs.sv
design/ser_tx_shifter.sv
design/ser_tx_status.sv
design/ser_tx_top.sv
dv/ser_tx_checker.sv
dv/ser_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ser_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
   --top-module ser_tx_tb -f all.f --Mdir obj_dir -o ser_tx_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build returned status $status"
   exit 1
fi

out=$(./obj_dir/ser_tx_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi

// ==== dv/ser_tx_tb.sv ====
// ser_tx testbench driving the AXI4-Lite port and checking the serial output
`timescale 1ns/1ns

module ser_tx_tb import ser_tx_pkg::*; ();

   localparam int NUM_WORDS = 40;
   localparam int READ_STALL = 200;

   logic                clk;
   logic                nreset;
   addr_t               awaddr;
   addr_t               araddr;
   logic                awvalid;
   logic                wvalid;
   logic                bready;
   logic                arvalid;
   logic                rready;
   data_t               wdata;
   logic [DATA_W/8-1:0] wstrb;
   logic                awready;
   logic                wready;
   logic                bvalid;
   logic                arready;
   logic                rvalid;
   logic [1:0]          bresp;
   logic [1:0]          rresp;
   data_t               rdata;
   logic                ser_data;
   logic                ser_strobe;
   logic                ser_busy;

   // random source and bookkeeping
   logic [31:0] lfsr = 32'hde93_c879;
   int          value_errors = 0;
   int          other_errors = 0;
   int          budget = 0;
   longint      cycle = 0;
   int          words_sent = 0;
   int          words_checked = 0;

   // extra cycles rready stays low on a read
   int          read_hold = 0;

   // word in flight, as the testbench expects it
   data_t       exp_word;
   size_t       exp_size;
   logic        exp_lsb;
   div_t        exp_div;

   // strobed bits and their cycle numbers
   logic        mon_bits[$];
   longint      mon_times[$];
   logic        busy_q = 1'b0;

   ser_tx_top uut (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   // ##############################
   // random numbers and reference
   // ##############################

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // bit i of the result is the i-th bit on the line
   function automatic data_t ref_bits(input data_t word, input size_t size, input logic lsbfirst);
      data_t seq;
      seq = '0;
      for (int i = 0; i < 32; i++) begin
         if (i < int'(size)) begin
            seq[i] = lsbfirst ? word[i] : word[31-i];
         end
      end
      return seq;
   endfunction

   // ##############################
   // compare tasks
   // ##############################

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act) begin
         value_errors++;
         $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         value_errors++;
         $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input count_t exp, input count_t act);
      if (exp !== act) begin
         value_errors++;
         $display("[ERROR] %s expected 0x%04h actual 0x%04h", name, exp, act);
      end
   endtask

   // ##############################
   // AXI tasks, entered on a falling edge
   // ##############################

   task automatic axi_write(input addr_t addr, input data_t data);
      logic [31:0] delay;
      int          n;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      n = 0;
      while (!(awready && wready)) begin
         @(negedge clk);
         n++;
         if (n > 50) begin
            other_errors++;
            $display("write to 0x%0h was never accepted", addr);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            return;
         end
      end
      @(posedge clk);
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      // response waits, next write must stall
      rand_bits(2, delay);
      repeat (delay) begin
         check_bit("bvalid", 1'b1, bvalid);
         check_bit("awready", 1'b0, awready);
         check_bit("wready", 1'b0, wready);
         @(negedge clk);
      end
      check_bit("bvalid", 1'b1, bvalid);
      check_bit("bresp okay", 1'b1, bresp == RESP_OKAY);
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      check_bit("bvalid", 1'b0, bvalid);
   endtask

   task automatic axi_read(input addr_t addr, output data_t data);
      logic [31:0] delay;
      data_t       first;
      int          n;
      araddr  = addr;
      arvalid = 1'b1;
      data    = '0;
      n = 0;
      while (!arready) begin
         @(negedge clk);
         n++;
         if (n > 50) begin
            other_errors++;
            $display("read from 0x%0h was never accepted", addr);
            arvalid = 1'b0;
            return;
         end
      end
      @(posedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      check_bit("rvalid", 1'b1, rvalid);
      first = rdata;
      // rdata frozen while rready stays low
      rand_bits(2, delay);
      repeat (delay + read_hold) begin
         @(negedge clk);
         check_bit("rvalid", 1'b1, rvalid);
         check_bit("arready", 1'b0, arready);
         check_data("rdata hold", first, rdata);
      end
      check_bit("rresp okay", 1'b1, rresp == RESP_OKAY);
      data   = rdata;
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      check_bit("rvalid", 1'b0, rvalid);
   endtask

   // ##############################
   // serial monitor and compare
   // ##############################

   always @(negedge clk) begin
      if (nreset && ser_strobe) begin
         mon_bits.push_back(ser_data);
         mon_times.push_back(cycle);
      end
   end

   task automatic compare_word();
      data_t got;
      got = '0;
      check_count("strobe count", count_t'(exp_size), count_t'(mon_bits.size()));
      foreach (mon_bits[i]) begin
         if (i < 32) got[i] = mon_bits[i];
      end
      check_data("serial bits", ref_bits(exp_word, exp_size, exp_lsb), got);
      for (int i = 1; i < mon_times.size(); i++) begin
         check_count("strobe spacing", count_t'(exp_div) + count_t'(1),
                     count_t'(mon_times[i] - mon_times[i-1]));
      end
      mon_bits.delete();
      mon_times.delete();
      words_checked++;
   endtask

   // end of transfer seen as busy falling
   always @(negedge clk) begin
      if (busy_q && !ser_busy) compare_word();
      busy_q = ser_busy;
   end

   task automatic wait_words();
      int n;
      n = 0;
      while (words_checked != words_sent) begin
         @(negedge clk);
         n++;
         if (n > 1000) begin
            other_errors++;
            $display("transfer %0d did not complete", words_sent);
            return;
         end
      end
   endtask

   // ##############################
   // stimulus
   // ##############################

   initial begin : main
      data_t       word_a[NUM_WORDS];
      size_t       size_a[NUM_WORDS];
      div_t        div_a[NUM_WORDS];
      logic        lsb_a[NUM_WORDS];
      logic        fill_a[NUM_WORDS];
      logic [31:0] v;
      data_t       ctrl;
      data_t       rd;
      nreset  = 1'b0;
      awaddr  = '0;
      araddr  = '0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '1;
      bready  = 1'b0;
      arvalid = 1'b0;
      rready  = 1'b0;

      // words drawn up front so the watchdog knows the run length
      for (int i = 0; i < NUM_WORDS; i++) begin
         rand_bits(32, v);
         word_a[i] = v;
         rand_bits(5, v);
         size_a[i] = size_t'(v[4:0]) + size_t'(1);
         rand_bits(3, v);
         div_a[i] = div_t'(v % 32'd6);
         rand_bits(1, v);
         lsb_a[i] = v[0];
         rand_bits(1, v);
         fill_a[i] = v[0];
         budget += int'(size_a[i]) * (int'(div_a[i]) + 1) + 20;
      end
      budget += 32 * 4 + 20 + READ_STALL + 1500;

      repeat (10) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);

      // register map and reset values
      check_bit("ser_data after reset", 1'b0, ser_data);
      axi_read(REG_STATUS, rd);
      check_data("status after reset", '0, rd);
      rand_bits(32, v);
      axi_write(REG_CTRL, v);
      axi_read(REG_CTRL, rd);
      check_data("ctrl readback", v, rd);
      check_bit("ser_data idle", v[CTRL_FILL_BIT], ser_data);
      axi_read(REG_DATA, rd);
      check_data("data readback", '0, rd);
      axi_read(addr_t'(4'hc), rd);
      check_data("unmapped read", '0, rd);

      // random words, both orders, dividers 0 to 5
      for (int i = 0; i < NUM_WORDS; i++) begin
         ctrl = '0;
         ctrl[CTRL_LSB_BIT] = lsb_a[i];
         ctrl[CTRL_FILL_BIT] = fill_a[i];
         ctrl[CTRL_SIZE_LO +: SIZE_W] = size_a[i];
         ctrl[CTRL_DIV_LO +: DIV_W] = div_a[i];
         axi_write(REG_CTRL, ctrl);
         check_bit("ser_data idle", fill_a[i], ser_data);
         exp_word = word_a[i];
         exp_size = size_a[i];
         exp_lsb  = lsb_a[i];
         exp_div  = div_a[i];
         axi_write(REG_DATA, word_a[i]);
         words_sent++;
         wait_words();
         check_bit("ser_data idle", fill_a[i], ser_data);
         axi_read(REG_STATUS, rd);
         check_count("done count", count_t'(words_sent), rd[STAT_CNT_LO +: CNT_W]);
         check_bit("status busy", 1'b0, rd[STAT_BUSY_BIT]);
         check_bit("status overrun", 1'b0, rd[STAT_OVR_BIT]);
      end

      // ##############################
      // overrun on a long msb-first word
      // ##############################
      ctrl = '0;
      ctrl[CTRL_SIZE_LO +: SIZE_W] = size_t'(32);
      ctrl[CTRL_DIV_LO +: DIV_W] = div_t'(3);
      axi_write(REG_CTRL, ctrl);
      exp_word = 32'hc3a5_0f96;
      exp_size = size_t'(32);
      exp_lsb  = 1'b0;
      exp_div  = div_t'(3);
      axi_write(REG_DATA, exp_word);
      words_sent++;
      check_bit("ser_busy", 1'b1, ser_busy);
      // this word is dropped
      axi_write(REG_DATA, 32'h1234_5678);
      // long stall so the word ends while rdata is held
      read_hold = READ_STALL;
      axi_read(REG_STATUS, rd);
      read_hold = 0;
      check_bit("status overrun", 1'b1, rd[STAT_OVR_BIT]);
      check_bit("status busy", 1'b1, rd[STAT_BUSY_BIT]);
      check_count("done count", count_t'(words_sent - 1), rd[STAT_CNT_LO +: CNT_W]);
      wait_words();
      axi_read(REG_STATUS, rd);
      check_bit("status overrun", 1'b1, rd[STAT_OVR_BIT]);
      check_count("done count", count_t'(words_sent), rd[STAT_CNT_LO +: CNT_W]);
      axi_write(REG_STATUS, data_t'(1) << STAT_OVR_BIT);
      axi_read(REG_STATUS, rd);
      check_bit("status overrun", 1'b0, rd[STAT_OVR_BIT]);
      check_count("done count", count_t'(words_sent), rd[STAT_CNT_LO +: CNT_W]);
      repeat (5) @(negedge clk);

      $display("errors: value=%0d other=%0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // ##############################
   // watchdog
   // ##############################
   initial begin : watchdog
      wait (budget > 0);
      repeat (budget) @(posedge clk);
      $display("run exceeded its limit of %0d cycles and was stopped", budget);
      $display("errors: value=%0d other=%0d", value_errors, other_errors + 1);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== dv/ser_tx_checker.sv ====
// ser_tx protocol checker with AXI handshake and strobe assertions
`timescale 1ns/1ns

module ser_tx_checker (
   input logic clk,
   input logic nreset,
   input logic awready,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready,
   input logic ser_strobe,
   input logic ser_busy
);

   // ##############################
   // AXI response channels
   // ##############################

   // write response held until taken
   a_bvalid_hold: assert property (@(posedge clk) disable iff (!nreset)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   // read data held until taken
   a_rvalid_hold: assert property (@(posedge clk) disable iff (!nreset)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // one write outstanding
   a_aw_backpressure: assert property (@(posedge clk) disable iff (!nreset)
      bvalid |-> !awready)
      else $error("awready high while bvalid pending");

   // ##############################
   // serial line
   // ##############################

   a_strobe_busy: assert property (@(posedge clk) disable iff (!nreset)
      ser_strobe |-> ser_busy)
      else $error("ser_strobe seen while idle");

endmodule

bind ser_tx_top ser_tx_checker u_checker (
   .clk        (clk),
   .nreset     (nreset),
   .awready    (awready),
   .bvalid     (bvalid),
   .bready     (bready),
   .rvalid     (rvalid),
   .rready     (rready),
   .ser_strobe (ser_strobe),
   .ser_busy   (ser_busy)
);

// ==== design/ser_tx_top.sv ====
// ser_tx top level connecting decode, execute and result stages
`timescale 1ns/1ns

module ser_tx_top import ser_tx_pkg::*; (
   input  logic                clk,
   input  logic                nreset,
   // AXI4-Lite slave
   input  addr_t               awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  data_t               wdata,
   input  logic [DATA_W/8-1:0] wstrb,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  addr_t               araddr,
   input  logic                arvalid,
   output logic                arready,
   output data_t               rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   // serial outputs
   output logic                ser_data,
   output logic                ser_strobe,
   output logic                ser_busy
);

   // regs to shifter
   logic       load;
   data_t      load_data;
   logic       lsbfirst;
   logic       fill;
   size_t      datasize;
   div_t       divider;

   // regs and status
   logic       clr_ovr;
   logic [1:0] rd_sel;
   data_t      ctrl_value;
   data_t      rd_value;

   // shifter to status
   logic       busy;
   logic       done;
   logic       overrun_pulse;

   // ##############################
   // decode
   // ##############################
   ser_tx_regs u_regs (
      .clk        (clk),
      .nreset     (nreset),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .load       (load),
      .load_data  (load_data),
      .lsbfirst   (lsbfirst),
      .fill       (fill),
      .datasize   (datasize),
      .divider    (divider),
      .clr_ovr    (clr_ovr),
      .rd_sel     (rd_sel),
      .ctrl_value (ctrl_value),
      .rd_value   (rd_value)
   );

   // ##############################
   // execute
   // ##############################
   ser_tx_shifter u_shifter (
      .clk           (clk),
      .nreset        (nreset),
      .load          (load),
      .load_data     (load_data),
      .lsbfirst      (lsbfirst),
      .fill          (fill),
      .datasize      (datasize),
      .divider       (divider),
      .ser_data      (ser_data),
      .ser_strobe    (ser_strobe),
      .busy          (busy),
      .done          (done),
      .overrun_pulse (overrun_pulse)
   );

   // result
   ser_tx_status u_status (
      .clk           (clk),
      .nreset        (nreset),
      .busy          (busy),
      .done          (done),
      .overrun_pulse (overrun_pulse),
      .clr_ovr       (clr_ovr),
      .rd_sel        (rd_sel),
      .ctrl_value    (ctrl_value),
      .rd_value      (rd_value)
   );

   // transfer in progress
   assign ser_busy = busy;

endmodule

// ==== design/ser_tx_status.sv ====
// ser_tx result stage: done counter, sticky overrun flag and read data mux
`timescale 1ns/1ns

module ser_tx_status import ser_tx_pkg::*; (
   input  logic       clk,
   input  logic       nreset,
   // from shifter
   input  logic       busy,
   input  logic       done,
   input  logic       overrun_pulse,
   // from regs
   input  logic       clr_ovr,
   input  logic [1:0] rd_sel,
   input  data_t      ctrl_value,
   // back to regs
   output data_t      rd_value
);

   count_t done_cnt;
   logic   ovr;
   data_t  status_word;

   // ##############################
   // counters and flags
   // ##############################

   // completed words, wraps at 16 bits
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         done_cnt <= '0;
      end else if (done) begin
         done_cnt <= done_cnt + count_t'(1);
      end
   end

   // sticky overrun
   // set beats clear in the same cycle
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ovr <= 1'b0;
      end else if (overrun_pulse) begin
         ovr <= 1'b1;
      end else if (clr_ovr) begin
         ovr <= 1'b0;
      end
   end

   // ##############################
   // read mux
   // ##############################

   // status word assembly
   always_comb begin
      status_word                           = '0;
      status_word[STAT_BUSY_BIT]            = busy;
      status_word[STAT_OVR_BIT]             = ovr;
      status_word[STAT_CNT_LO +: CNT_W]     = done_cnt;
   end

   // data register and unmapped space read zero
   always_comb begin
      case (rd_sel)
         SEL_CTRL:   rd_value = ctrl_value;
         SEL_STATUS: rd_value = status_word;
         default:    rd_value = '0;
      endcase
   end

endmodule

// ==== design/ser_tx_shifter.sv ====
// ser_tx execute stage: rate divider, bit counter and shift register
`timescale 1ns/1ns

module ser_tx_shifter import ser_tx_pkg::*; (
   input  logic  clk,
   input  logic  nreset,
   // load and settings from regs
   input  logic  load,
   input  data_t load_data,
   input  logic  lsbfirst,
   input  logic  fill,
   input  size_t datasize,
   input  div_t  divider,
   // serial line
   output logic  ser_data,
   output logic  ser_strobe,
   // to status
   output logic  busy,
   output logic  done,
   output logic  overrun_pulse
);

   // shift register and bits left
   data_t shreg;
   size_t count;

   // settings latched at load
   logic  order_q;
   div_t  div_q;

   // rate counter
   div_t  rate_cnt;
   logic  start;
   logic  strobe;

   // ##############################
   // control
   // ##############################

   // busy while bits remain
   assign busy  = |count;
   assign start = load & ~busy;

   // dropped word, status keeps the flag
   assign overrun_pulse = load & busy;

   // last cycle of each bit period
   assign strobe     = busy & (rate_cnt == div_q);
   assign ser_strobe = strobe;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count    <= '0;
         rate_cnt <= '0;
         order_q  <= 1'b0;
         div_q    <= '0;
      end else if (start) begin
         count    <= datasize;
         rate_cnt <= '0;
         order_q  <= lsbfirst;
         div_q    <= divider;
      end else if (strobe) begin
         count    <= count - 1'b1;
         rate_cnt <= '0;
      end else if (busy) begin
         rate_cnt <= rate_cnt + 1'b1;
      end
   end

   // pulse right after the final strobe, busy drops here too
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         done <= 1'b0;
      end else begin
         done <= strobe && (count == size_t'(1));
      end
   end

   // ##############################
   // shift register
   // ##############################

   // shift toward the output end, fill enters behind
   always_ff @(posedge clk) begin
      if (start) begin
         shreg <= load_data;
      end else if (strobe && order_q) begin
         shreg <= {fill, shreg[DATA_W-1:1]};
      end else if (strobe) begin
         shreg <= {shreg[DATA_W-2:0], fill};
      end
   end

   // idle line rests at fill level
   always_comb begin
      if (!busy) begin
         ser_data = fill;
      end else if (order_q) begin
         ser_data = shreg[0];
      end else begin
         ser_data = shreg[DATA_W-1];
      end
   end

endmodule

// ==== design/ser_tx_regs.sv ====
// ser_tx decode stage: AXI4-Lite slave, control register, load and clear strobes
`timescale 1ns/1ns

module ser_tx_regs import ser_tx_pkg::*; (
   input  logic                clk,
   input  logic                nreset,
   // write address channel
   input  addr_t               awaddr,
   input  logic                awvalid,
   output logic                awready,
   // write data channel
   input  data_t               wdata,
   input  logic [DATA_W/8-1:0] wstrb,
   input  logic                wvalid,
   output logic                wready,
   // write response channel
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   // read address channel
   input  addr_t               araddr,
   input  logic                arvalid,
   output logic                arready,
   // read data channel
   output data_t               rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   // to shifter
   output logic                load,
   output data_t               load_data,
   output logic                lsbfirst,
   output logic                fill,
   output size_t               datasize,
   output div_t                divider,
   // to and from status
   output logic                clr_ovr,
   output logic [1:0]          rd_sel,
   output data_t               ctrl_value,
   input  data_t               rd_value
);

   // handshakes
   logic       wr_fire;
   logic       rd_fire;
   logic [1:0] wr_sel;

   // control register image
   data_t      ctrl_q;

   // read data capture
   logic       rd_first;
   data_t      rd_hold;

   // ##############################
   // write channel
   // ##############################

   // one write outstanding, back-pressure while response waits
   assign awready = ~bvalid;
   assign wready  = ~bvalid;

   // address and data must arrive together
   assign wr_fire = awvalid & wvalid & awready & wready;
   assign wr_sel  = awaddr[3:2];

   // full-word writes only, byte strobes not decoded
   assign bresp = RESP_OKAY;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         bvalid <= 1'b0;
      end else if (wr_fire) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   // control register, reads back as written
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ctrl_q <= '0;
      end else if (wr_fire && wr_sel == SEL_CTRL) begin
         ctrl_q <= wdata;
      end
   end

   // strobes line up with bvalid rising
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         load    <= 1'b0;
         clr_ovr <= 1'b0;
      end else begin
         load    <= wr_fire && (wr_sel == SEL_DATA);
         clr_ovr <= wr_fire && (wr_sel == SEL_STATUS) && wdata[STAT_OVR_BIT];
      end
   end

   // data word payload
   always_ff @(posedge clk) begin
      if (wr_fire && wr_sel == SEL_DATA) begin
         load_data <= wdata;
      end
   end

   // control fields out
   assign lsbfirst   = ctrl_q[CTRL_LSB_BIT];
   assign fill       = ctrl_q[CTRL_FILL_BIT];
   assign datasize   = ctrl_q[CTRL_SIZE_LO +: SIZE_W];
   assign divider    = ctrl_q[CTRL_DIV_LO +: DIV_W];
   assign ctrl_value = ctrl_q;

   // ##############################
   // read channel
   // ##############################

   assign arready = ~rvalid;
   assign rd_fire = arvalid & arready;
   assign rresp   = RESP_OKAY;

   // index latched with the handshake, status mux does the rest
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rvalid   <= 1'b0;
         rd_first <= 1'b0;
         rd_sel   <= '0;
      end else begin
         rd_first <= rd_fire;
         if (rd_fire) begin
            rvalid <= 1'b1;
            rd_sel <= araddr[3:2];
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // snapshot at first data cycle
   always_ff @(posedge clk) begin
      if (rd_first) begin
         rd_hold <= rd_value;
      end
   end

   // live value in first cycle then frozen until rready
   assign rdata = rd_first ? rd_value : rd_hold;

endmodule

// ==== design/ser_tx_pkg.sv ====
// ser_tx shared package with register map, field positions and common types
package ser_tx_pkg;

   // ##############################
   // widths
   // ##############################
   localparam int DATA_W = 32;
   localparam int SIZE_W = 6;
   localparam int DIV_W  = 16;
   localparam int CNT_W  = 16;
   localparam int ADDR_W = 4;

   // parallel word, bit count, rate divider, word count, bus address
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SIZE_W-1:0] size_t;
   typedef logic [DIV_W-1:0]  div_t;
   typedef logic [CNT_W-1:0]  count_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // ##############################
   // register map
   // ##############################
   localparam addr_t REG_CTRL   = 4'h0;
   localparam addr_t REG_DATA   = 4'h4;
   localparam addr_t REG_STATUS = 4'h8;

   // word index of each register (address bits 3:2)
   localparam logic [1:0] SEL_CTRL   = REG_CTRL[3:2];
   localparam logic [1:0] SEL_DATA   = REG_DATA[3:2];
   localparam logic [1:0] SEL_STATUS = REG_STATUS[3:2];

   // control fields
   localparam int CTRL_LSB_BIT  = 0;
   localparam int CTRL_FILL_BIT = 1;
   localparam int CTRL_SIZE_LO  = 8;
   localparam int CTRL_DIV_LO   = 16;

   // status fields
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_OVR_BIT  = 1;
   localparam int STAT_CNT_LO   = 16;

   // every access answers okay
   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
